/* tb.f */
+incdir+.
fifo_pkg.sv
fifo_ptr_if.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
fifo_ram.sv
fifo_sync.sv
tb_fifo_sync.sv

/* Bender.yml */
package:
  name: fifo_sync

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fifo_pkg.sv
      - fifo_ptr_if.sv
      - fifo_wr_ctrl.sv
      - fifo_rd_ctrl.sv
      - fifo_ram.sv
      - fifo_sync.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fifo_sync.sv

/* tb_fifo_sync.sv */
// self-checking testbench for the single-clock FIFO, stimulus from a fixed seed
// reference model follows the acceptance rules, using the DUT flags from before each edge

`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module tb_fifo_sync;

   import fifo_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   localparam int EDGE_CYCLES  = FIFO_DEPTH + 4;
   localparam int MIX_CYCLES   = 400;
   localparam int IDLE_CYCLES  = 4;
   localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * EDGE_CYCLES + MIX_CYCLES + IDLE_CYCLES;
   localparam int MARGIN       = 50;

   // DUT ports
   logic    pos_clk = 1'b0;
   logic    aresetn;
   logic    we_i;
   word_t   wdata_i;
   logic    re_i;
   word_t   rdata_o;
   logic    full_o;
   logic    afull_o;
   logic    empty_o;
   logic    aempty_o;
   level_t  level_o;
   logic    wack_o;
   logic    overflow_o;
   logic    dvld_o;
   logic    underflow_o;

   integer  seed;

   // reference model state
   word_t   ref_q[$];
   int      occ;
   word_t   exp_rdata;
   logic    exp_wack;
   logic    exp_ovf;
   logic    exp_dvld;
   logic    exp_unf;
   logic    acc_w;
   logic    acc_r;

   fifo_sync i_fifo_sync (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .wdata_i     (wdata_i),
      .re_i        (re_i),
      .rdata_o     (rdata_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .level_o     (level_o),
      .wack_o      (wack_o),
      .overflow_o  (overflow_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   always #(CLK_PERIOD / 2) pos_clk = ~pos_clk;

   task automatic stop_with_failure();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
   endtask

   // one request cycle, inputs change right after the rising edge
   task automatic drive_cycle(input logic wr, input logic rd);
      @(posedge pos_clk);
      we_i    <= wr;
      re_i    <= rd;
      wdata_i <= word_t'($random(seed));
   endtask

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------

   // requests that the FIFO takes, per its flags before the edge
   assign acc_w = we_i & ~full_o;
   assign acc_r = re_i & ~empty_o;

   always @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         ref_q.delete();
         occ       <= 0;
         exp_rdata <= '0;
         exp_wack  <= 1'b0;
         exp_ovf   <= 1'b0;
         exp_dvld  <= 1'b0;
         exp_unf   <= 1'b0;
      end else begin
         // oldest word leaves before the new one joins
         if (acc_r && ref_q.size() != 0) begin
            exp_rdata <= ref_q.pop_front();
         end
         if (acc_w) begin
            ref_q.push_back(wdata_i);
         end
         occ      <= occ + (acc_w ? 1 : 0) - (acc_r ? 1 : 0);
         exp_wack <= acc_w;
         exp_ovf  <= we_i & full_o;
         exp_dvld <= acc_r;
         exp_unf  <= re_i & empty_o;
      end
   end

   // ------------------------------------------------------------------------
   // checks, sampled before the edge
   // ------------------------------------------------------------------------
   a_reset_state : assert property (@(posedge pos_clk) $rose(aresetn) |->
      empty_o && aempty_o && !full_o && !afull_o && level_o == 0 &&
      !wack_o && !overflow_o && !dvld_o && !underflow_o)
      else begin
         $display("outputs are not at their reset values after reset release");
         stop_with_failure();
      end

   a_level : assert property (@(posedge pos_clk) disable iff (!aresetn) level_o == occ)
      else report_mismatch("level_o", $sampled(occ), $sampled(level_o));
   a_full : assert property (@(posedge pos_clk) disable iff (!aresetn)
      full_o == (occ == FIFO_DEPTH))
      else report_mismatch("full_o", $sampled(occ == FIFO_DEPTH), $sampled(full_o));
   a_afull : assert property (@(posedge pos_clk) disable iff (!aresetn)
      afull_o == (occ >= `FIFO_AFULL_LEVEL))
      else report_mismatch("afull_o", $sampled(occ >= `FIFO_AFULL_LEVEL), $sampled(afull_o));
   a_empty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      empty_o == (occ == 0))
      else report_mismatch("empty_o", $sampled(occ == 0), $sampled(empty_o));
   a_aempty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      aempty_o == (occ <= `FIFO_AEMPTY_LEVEL))
      else report_mismatch("aempty_o", $sampled(occ <= `FIFO_AEMPTY_LEVEL), $sampled(aempty_o));

   // one-cycle pulses
   a_wack : assert property (@(posedge pos_clk) disable iff (!aresetn) wack_o == exp_wack)
      else report_mismatch("wack_o", $sampled(exp_wack), $sampled(wack_o));
   a_ovf : assert property (@(posedge pos_clk) disable iff (!aresetn) overflow_o == exp_ovf)
      else report_mismatch("overflow_o", $sampled(exp_ovf), $sampled(overflow_o));
   a_dvld : assert property (@(posedge pos_clk) disable iff (!aresetn) dvld_o == exp_dvld)
      else report_mismatch("dvld_o", $sampled(exp_dvld), $sampled(dvld_o));
   a_unf : assert property (@(posedge pos_clk) disable iff (!aresetn) underflow_o == exp_unf)
      else report_mismatch("underflow_o", $sampled(exp_unf), $sampled(underflow_o));

   // read word in order
   a_rdata : assert property (@(posedge pos_clk) disable iff (!aresetn)
      dvld_o |-> rdata_o == exp_rdata)
      else report_mismatch("rdata_o", $sampled(exp_rdata), $sampled(rdata_o));

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   initial begin
      int w_lim;
      seed    = 32'hda56_f1b1;
      aresetn = 1'b0;
      we_i    = 1'b0;
      re_i    = 1'b0;
      wdata_i = '0;
      repeat (RESET_CYCLES) @(posedge pos_clk);
      aresetn <= 1'b1;
      // fill past full, the last writes overflow
      repeat (EDGE_CYCLES) drive_cycle(1'b1, 1'b0);
      // drain past empty, the last reads underflow
      repeat (EDGE_CYCLES) drive_cycle(1'b0, 1'b1);
      // random mix, write-heavy, balanced, read-heavy, balanced
      for (int i = 0; i < MIX_CYCLES; i++) begin
         case ((i * 4) / MIX_CYCLES)
            0:       w_lim = 3;
            2:       w_lim = 1;
            default: w_lim = 2;
         endcase
         drive_cycle(($random(seed) & 3) < w_lim, ($random(seed) & 3) < (4 - w_lim));
      end
      // let the last pulses come out
      repeat (IDLE_CYCLES) drive_cycle(1'b0, 1'b0);
      $display("Simulation finished: PASS");
      $finish;
   end

   // watchdog
   initial begin
      #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN));
      $display("watchdog expired before the test sequence finished");
      stop_with_failure();
   end

endmodule

`default_nettype wire

/* fifo_sync.sv */
// single-clock FIFO top, stop on full and stop on empty
// every status output is registered, one cycle after the request edge

`timescale 1ns/1ps
`default_nettype none

module fifo_sync (
   input  logic               pos_clk,
   input  logic               aresetn,
   // write port
   input  logic               we_i,
   input  fifo_pkg::word_t    wdata_i,
   // read port
   input  logic               re_i,
   output fifo_pkg::word_t    rdata_o,
   // status
   output logic               full_o,
   output logic               afull_o,
   output logic               empty_o,
   output logic               aempty_o,
   output fifo_pkg::level_t   level_o,
   // pulses
   output logic               wack_o,
   output logic               overflow_o,
   output logic               dvld_o,
   output logic               underflow_o
);

   // pointers and accepted strobes
   fifo_ptr_if i_ptr ();

   // producer
   fifo_wr_ctrl i_wr_ctrl (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we_i),
      .ptr        (i_ptr.wr_side),
      .full_o     (full_o),
      .afull_o    (afull_o),
      .level_o    (level_o),
      .wack_o     (wack_o),
      .overflow_o (overflow_o)
   );

   // consumer
   fifo_rd_ctrl i_rd_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .ptr         (i_ptr.rd_side),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   // buffer
   fifo_ram i_ram (
      .pos_clk (pos_clk),
      .ptr     (i_ptr.mem_side),
      .wdata_i (wdata_i),
      .rdata_o (rdata_o)
   );

endmodule

`default_nettype wire

/* fifo_ram.sv */
// storage array, one write port and one registered read port
// read word changes only on an accepted pop and holds otherwise

`timescale 1ns/1ps
`default_nettype none

module fifo_ram (
   input  logic              pos_clk,
   fifo_ptr_if.mem_side      ptr,
   input  fifo_pkg::word_t   wdata_i,
   output fifo_pkg::word_t   rdata_o
);

   import fifo_pkg::*;

   word_t   mem [FIFO_DEPTH];
   word_t   rdata_q;
   addr_t   waddr;
   addr_t   raddr;

   // low bits of the pointers, wrap bit dropped
   assign waddr = addr_t'(ptr.wr_ptr);
   assign raddr = addr_t'(ptr.rd_ptr);

   // -------------------------------------------------------------------------
   // array access
   // -------------------------------------------------------------------------

   // same address on push and pop only when full or empty,
   // and then one of the two is refused upstream
   always_ff @(posedge pos_clk) begin
      if (ptr.push) begin
         mem[waddr] <= wdata_i;
      end
      if (ptr.pop) begin
         rdata_q <= mem[raddr];
      end
   end

   assign rdata_o = rdata_q;

   // stored words must be clean
   a_wdata_known : assert property (
      @(posedge pos_clk)
      ptr.push |-> !$isunknown(wdata_i)
   );

endmodule

`default_nettype wire

/* fifo_rd_ctrl.sv */
// read side of the FIFO, stops on empty
// a read while empty pulses underflow_o and gives no data valid

`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module fifo_rd_ctrl (
   input  logic           pos_clk,
   input  logic           aresetn,
   input  logic           re_i,
   fifo_ptr_if.rd_side    ptr,
   output logic           empty_o,
   output logic           aempty_o,
   output logic           dvld_o,
   output logic           underflow_o
);

   import fifo_pkg::*;

   // registered state
   ptr_t    rd_ptr_q;
   logic    empty_q;
   logic    aempty_q;
   logic    dvld_q;
   logic    underflow_q;

   // next-state terms
   logic    pop;
   ptr_t    rd_ptr_d;
   ptr_t    wr_ptr_d;
   level_t  level_d;

   // -------------------------------------------------------------------------
   // accept and advance
   // -------------------------------------------------------------------------

   // read only goes out while not empty
   assign pop      = re_i & ~empty_q;
   assign rd_ptr_d = rd_ptr_q + ptr_t'(pop);

   // producer pointer after this cycle's push
   assign wr_ptr_d = ptr.wr_ptr + ptr_t'(ptr.push);
   assign level_d  = level_t'(wr_ptr_d - rd_ptr_d);

   assign ptr.rd_ptr = rd_ptr_q;
   assign ptr.pop    = pop;

   // -------------------------------------------------------------------------
   // status registers
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_ptr_q    <= '0;
         empty_q     <= 1'b1;
         aempty_q    <= 1'b1;
         dvld_q      <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         rd_ptr_q    <= rd_ptr_d;
         empty_q     <= (level_d == '0);
         aempty_q    <= (level_d <= level_t'(`FIFO_AEMPTY_LEVEL));
         // lines up with the registered read word in the buffer
         dvld_q      <= pop;
         underflow_q <= re_i & empty_q;
      end
   end

   assign empty_o     = empty_q;
   assign aempty_o    = aempty_q;
   assign dvld_o      = dvld_q;
   assign underflow_o = underflow_q;

   // no pop may reach the buffer while the pointers show it empty
   a_no_pop_empty : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      ptr.pop |-> (ptr.wr_ptr != rd_ptr_q)
   );

endmodule

`default_nettype wire

/* fifo_wr_ctrl.sv */
// write side of the FIFO, stops on full
// a write while full is dropped and pulses overflow_o for one cycle

`timescale 1ns/1ps
`default_nettype none

`include "fifo_params.svh"

module fifo_wr_ctrl (
   input  logic               pos_clk,
   input  logic               aresetn,
   input  logic               we_i,
   fifo_ptr_if.wr_side        ptr,
   output logic               full_o,
   output logic               afull_o,
   output fifo_pkg::level_t   level_o,
   output logic               wack_o,
   output logic               overflow_o
);

   import fifo_pkg::*;

   // registered state
   ptr_t    wr_ptr_q;
   logic    full_q;
   logic    afull_q;
   level_t  level_q;
   logic    wack_q;
   logic    overflow_q;

   // next-state terms
   logic    push;
   ptr_t    wr_ptr_d;
   ptr_t    rd_ptr_d;
   level_t  level_d;

   // -------------------------------------------------------------------------
   // accept and advance
   // -------------------------------------------------------------------------

   // write only goes in while not full
   assign push     = we_i & ~full_q;
   assign wr_ptr_d = wr_ptr_q + ptr_t'(push);

   // peer pointer after its own pop this cycle
   assign rd_ptr_d = ptr.rd_ptr + ptr_t'(ptr.pop);

   // difference wraps on the extra bit, gives 0..depth
   assign level_d  = level_t'(wr_ptr_d - rd_ptr_d);

   assign ptr.wr_ptr = wr_ptr_q;
   assign ptr.push   = push;

   // -------------------------------------------------------------------------
   // status registers
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_ptr_q   <= '0;
         full_q     <= 1'b0;
         afull_q    <= 1'b0;
         level_q    <= '0;
         wack_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         wr_ptr_q   <= wr_ptr_d;
         full_q     <= (level_d == level_t'(FIFO_DEPTH));
         afull_q    <= (level_d >= level_t'(`FIFO_AFULL_LEVEL));
         level_q    <= level_d;
         // pulses, one cycle after the request edge
         wack_q     <= push;
         overflow_q <= we_i & full_q;
      end
   end

   assign full_o     = full_q;
   assign afull_o    = afull_q;
   assign level_o    = level_q;
   assign wack_o     = wack_q;
   assign overflow_o = overflow_q;

   // full must mean the live pointers are exactly depth apart
   a_full_level : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      full_q |-> (level_t'(wr_ptr_q - ptr.rd_ptr) == level_t'(FIFO_DEPTH))
   );

endmodule

`default_nettype wire

/* fifo_ptr_if.sv */
// pointer and strobe exchange between producer, consumer and buffer
// push and pop are combinational strobes of accepted requests

`timescale 1ns/1ps
`default_nettype none

interface fifo_ptr_if;

   // producer side
   fifo_pkg::ptr_t wr_ptr;
   logic           push;

   // consumer side
   fifo_pkg::ptr_t rd_ptr;
   logic           pop;

   // write control owns the write pointer
   modport wr_side (
      output wr_ptr,
      output push,
      input  rd_ptr,
      input  pop
   );

   // read control owns the read pointer
   modport rd_side (
      output rd_ptr,
      output pop,
      input  wr_ptr,
      input  push
   );

   // storage only watches
   modport mem_side (
      input wr_ptr,
      input push,
      input rd_ptr,
      input pop
   );

endinterface

`default_nettype wire

/* fifo_pkg.sv */
// types shared by the FIFO blocks, all sized from the params header
// pointers carry one extra bit to tell full from empty

`default_nettype none

`include "fifo_params.svh"

package fifo_pkg;

   // entry count
   localparam int FIFO_DEPTH = 1 << `FIFO_DEPTH_LOG2;

   // one stored word
   typedef logic [`FIFO_WIDTH-1:0] word_t;

   // write or read pointer, msb is the wrap bit
   typedef logic [`FIFO_DEPTH_LOG2:0] ptr_t;

   // buffer address, low bits of a pointer
   typedef logic [`FIFO_DEPTH_LOG2-1:0] addr_t;

   // occupancy 0..depth
   typedef logic [`FIFO_DEPTH_LOG2:0] level_t;

endpackage

`default_nettype wire

/* fifo_params.svh */
// build-time sizes of the FIFO, the depth is a power of two
// almost-flag levels are static and must lie within 0..depth

`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// log2 of the entry count
`define FIFO_DEPTH_LOG2 4

// bits per stored word
`define FIFO_WIDTH 16

// almost full rises at this occupancy or above
`define FIFO_AFULL_LEVEL 12

// almost empty is high at this occupancy or below
`define FIFO_AEMPTY_LEVEL 3

`endif
